//--- logic/rename_pkg.sv
/* Rename stage shared definitions
   Sizes, tag types, request/response and checkpoint structs */
package rename_pkg;

  // Sizes
  localparam int NUM_AREG   = 32;                  // Architectural regs
  localparam int NUM_PREG   = 64;                  // Physical regs
  localparam int FL_DEPTH   = NUM_PREG - NUM_AREG; // Free-list entries, 32
  localparam int CKPT_DEPTH = 4;                   // Branch checkpoints
  localparam int CKPT_PTR_W = $clog2(CKPT_DEPTH);

  // Tags and pointers
  typedef logic [$clog2(NUM_AREG)-1:0] areg_t;      // 5 bits
  typedef logic [$clog2(NUM_PREG)-1:0] preg_t;      // 6 bits
  typedef logic [$clog2(FL_DEPTH)-1:0] fl_ptr_t;    // Wraps at 32
  typedef logic [$clog2(FL_DEPTH):0]   fl_cnt_t;    // 0..32
  typedef logic [CKPT_PTR_W-1:0]       ckpt_ptr_t;
  typedef logic [CKPT_PTR_W:0]         ckpt_cnt_t;  // 0..4

  // Whole map table, entry r holds the tag of arch reg r
  typedef preg_t [NUM_AREG-1:0] map_t;

  // From decoder
  typedef struct packed {
    areg_t rd;
    areg_t rs1;
    areg_t rs2;
    logic  has_dest;   // Writes rd
    logic  is_branch;  // Needs a checkpoint
  } rename_req_t;

  // To dispatch
  typedef struct packed {
    preg_t   ps1;
    preg_t   ps2;
    preg_t   pd;       // Zero when no dest
    preg_t   old_pd;   // Freed by ROB at retire
    fl_ptr_t fl_head;
  } rename_rsp_t;

  // Snapshot taken at a branch
  typedef struct packed {
    map_t    map;
    fl_ptr_t fl_head;
  } checkpoint_t;

endpackage

//--- logic/free_list.sv
`timescale 1ns/1ns
/* Free list of physical tags
   Circular queue with empty bypass of a retiring tag and head restore */
module free_list (
  input  logic                clk,
  input  logic                rst,
  input  logic                alloc_i,         // Rename takes a tag
  input  logic                retire_en_i,     // ROB hands back a tag
  input  rename_pkg::preg_t   retire_preg_i,
  input  logic                restore_en_i,    // Mispredict recovery
  input  rename_pkg::fl_ptr_t restore_head_i,  // Head saved at the branch
  output rename_pkg::preg_t   alloc_preg_o,
  output logic                empty_o,
  output rename_pkg::fl_ptr_t head_o
);

  rename_pkg::preg_t   fl_q [rename_pkg::FL_DEPTH];  // Tag storage
  rename_pkg::fl_ptr_t head_q;                        // Next tag to hand out
  rename_pkg::fl_ptr_t tail_q;                        // Next slot to fill
  rename_pkg::fl_cnt_t count_q;
  rename_pkg::fl_cnt_t count_d;
  rename_pkg::fl_ptr_t restore_dist;                  // Tags handed out since the branch
  logic                bypass;
  logic                do_alloc;
  logic                do_retire;

  assign empty_o = (count_q == '0);

  // Empty list, retiring tag goes straight to the renamer
  assign bypass = empty_o & alloc_i & retire_en_i & ~restore_en_i;

  // Restore wins over allocate
  assign do_alloc  = alloc_i & ~empty_o & ~restore_en_i;
  assign do_retire = retire_en_i & ~bypass;

  // Pointers wrap mod 32, so plain subtraction gives the distance
  assign restore_dist = head_q - restore_head_i;

  assign alloc_preg_o = empty_o ? retire_preg_i : fl_q[head_q];
  assign head_o       = head_q;

  // Storage and tail
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < rename_pkg::FL_DEPTH; i++) begin
        fl_q[i] <= rename_pkg::preg_t'(rename_pkg::NUM_AREG + i);  // p32..p63
      end
      tail_q <= '0;
    end else if (do_retire) begin
      fl_q[tail_q] <= retire_preg_i;
      tail_q       <= tail_q + 1'b1;  // Wraps at 32
    end
  end

  // Head
  always_ff @(posedge clk) begin
    if (rst) begin
      head_q <= '0;
    end else if (restore_en_i) begin
      head_q <= restore_head_i;       // Roll back to the branch
    end else if (do_alloc) begin
      head_q <= head_q + 1'b1;
    end
  end

  // Count next state
  always_comb begin
    count_d = count_q;
    if (restore_en_i) begin
      // Tags taken after the branch come back, plus a retire this cycle
      count_d = count_q + rename_pkg::fl_cnt_t'(restore_dist)
              + rename_pkg::fl_cnt_t'(retire_en_i);
    end else if (do_alloc && !do_retire) begin
      count_d = count_q - 1'b1;
    end else if (do_retire && !do_alloc) begin
      count_d = count_q + 1'b1;
    end
    // Both or bypass, count unchanged
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      count_q <= rename_pkg::fl_cnt_t'(rename_pkg::FL_DEPTH);  // Starts full
    end else begin
      count_q <= count_d;
    end
  end

endmodule

//--- logic/map_table.sv
`timescale 1ns/1ns
/* Register map table
   Arch to phys map, combinational source lookup, whole-map restore */
module map_table (
  input  logic                    clk,
  input  logic                    rst,
  input  rename_pkg::rename_req_t req_i,          // rd/rs1/rs2 indices
  input  logic                    write_en_i,     // Rename with a dest
  input  rename_pkg::preg_t       alloc_preg_i,   // New tag for rd
  input  logic                    restore_en_i,   // Mispredict recovery
  input  rename_pkg::map_t        restore_map_i,  // Map saved at the branch
  output rename_pkg::preg_t       ps1_o,
  output rename_pkg::preg_t       ps2_o,
  output rename_pkg::preg_t       old_pd_o,       // Current tag of rd
  output rename_pkg::map_t        map_o           // For checkpoints
);

  rename_pkg::map_t map_q;

  // Lookups see the map before this cycle's write
  assign ps1_o    = map_q[req_i.rs1];
  assign ps2_o    = map_q[req_i.rs2];
  assign old_pd_o = map_q[req_i.rd];

  assign map_o = map_q;

  // Map update
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int r = 0; r < rename_pkg::NUM_AREG; r++) begin
        map_q[r] <= rename_pkg::preg_t'(r);  // r -> p r
      end
    end else if (restore_en_i) begin
      map_q <= restore_map_i;                // Whole map back in one edge
    end else if (write_en_i) begin
      map_q[req_i.rd] <= alloc_preg_i;
    end
  end

endmodule

//--- logic/checkpoint_queue.sv
`timescale 1ns/1ns
/* Branch checkpoint queue
   Oldest-first FIFO of map/head snapshots, flushed on mispredict */
module checkpoint_queue (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    push_i,          // Branch renamed
  input  rename_pkg::checkpoint_t push_data_i,
  input  logic                    resolve_en_i,    // Oldest branch resolves
  input  logic                    mispredict_i,    // Qualifies resolve_en_i
  output logic                    full_o,
  output logic                    restore_en_o,
  output rename_pkg::checkpoint_t restore_data_o   // Oldest snapshot
);

  rename_pkg::checkpoint_t ckpt_q [rename_pkg::CKPT_DEPTH];  // Snapshot storage
  rename_pkg::ckpt_ptr_t   rd_ptr_q;   // Oldest
  rename_pkg::ckpt_ptr_t   wr_ptr_q;   // Next free slot
  rename_pkg::ckpt_cnt_t   count_q;
  logic                    empty;
  logic                    do_push;
  logic                    do_pop;

  assign empty  = (count_q == '0);
  assign full_o = (count_q == rename_pkg::ckpt_cnt_t'(rename_pkg::CKPT_DEPTH));

  // Branches resolve in order, so a mispredict always hits the oldest
  assign restore_en_o   = resolve_en_i & mispredict_i;
  assign restore_data_o = ckpt_q[rd_ptr_q];

  assign do_push = push_i & ~full_o & ~restore_en_o;
  assign do_pop  = resolve_en_i & ~mispredict_i & ~empty;  // Correct branch

  // Snapshot storage
  always_ff @(posedge clk) begin
    if (do_push) begin
      ckpt_q[wr_ptr_q] <= push_data_i;
    end
  end

  // Pointers and count
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else if (restore_en_o) begin
      // Mispredict drops this and every younger snapshot
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;  // Idle or push+pop
      endcase
    end
  end

endmodule

//--- logic/rename_top.sv
`timescale 1ns/1ns
/* Register rename stage, single wide
   Free list, map table and branch checkpoints with ready and response logic */
module rename_top (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    dispatch_en_i,   // Decoder has a request
  input  rename_pkg::rename_req_t req_i,
  input  logic                    retire_en_i,     // ROB frees a tag
  input  rename_pkg::preg_t       retire_preg_i,
  input  logic                    resolve_en_i,    // Oldest branch resolves
  input  logic                    mispredict_i,
  output rename_pkg::rename_rsp_t rsp_o,
  output logic                    rsp_vld_o,
  output logic                    rename_ready_o
);

  logic                    restore_en;     // From checkpoint queue
  rename_pkg::checkpoint_t restore_data;
  rename_pkg::checkpoint_t push_data;
  logic                    fl_empty;
  logic                    ckpt_full;
  logic                    rename_en;
  logic                    alloc;
  logic                    push;
  rename_pkg::preg_t       alloc_preg;
  rename_pkg::preg_t       ps1;
  rename_pkg::preg_t       ps2;
  rename_pkg::preg_t       old_pd;
  rename_pkg::fl_ptr_t     fl_head;
  rename_pkg::map_t        cur_map;

  // Stall on no tag (unless one retires now) or no checkpoint slot
  assign rename_ready_o = ~(req_i.has_dest & fl_empty & ~retire_en_i)
                        & ~(req_i.is_branch & ckpt_full);

  assign rename_en = dispatch_en_i & rename_ready_o & ~restore_en;
  assign alloc     = rename_en & req_i.has_dest;
  assign push      = rename_en & req_i.is_branch;

  // Map before the branch's own write, head after its allocation
  assign push_data.map     = cur_map;
  assign push_data.fl_head = fl_head + rename_pkg::fl_ptr_t'(alloc & ~fl_empty);  // Bypass keeps head

  // Response, same cycle as the request
  assign rsp_vld_o      = rename_en;
  assign rsp_o.ps1      = ps1;
  assign rsp_o.ps2      = ps2;
  assign rsp_o.pd       = req_i.has_dest ? alloc_preg : '0;
  assign rsp_o.old_pd   = old_pd;
  assign rsp_o.fl_head  = fl_head;

  free_list free_list_i (
    .clk            (clk),
    .rst            (rst),
    .alloc_i        (alloc),
    .retire_en_i    (retire_en_i),
    .retire_preg_i  (retire_preg_i),
    .restore_en_i   (restore_en),
    .restore_head_i (restore_data.fl_head),
    .alloc_preg_o   (alloc_preg),
    .empty_o        (fl_empty),
    .head_o         (fl_head)
  );

  map_table map_table_i (
    .clk           (clk),
    .rst           (rst),
    .req_i         (req_i),
    .write_en_i    (alloc),          // Only renames with a dest write
    .alloc_preg_i  (alloc_preg),
    .restore_en_i  (restore_en),
    .restore_map_i (restore_data.map),
    .ps1_o         (ps1),
    .ps2_o         (ps2),
    .old_pd_o      (old_pd),
    .map_o         (cur_map)
  );

  checkpoint_queue checkpoint_queue_i (
    .clk            (clk),
    .rst            (rst),
    .push_i         (push),
    .push_data_i    (push_data),
    .resolve_en_i   (resolve_en_i),
    .mispredict_i   (mispredict_i),
    .full_o         (ckpt_full),
    .restore_en_o   (restore_en),
    .restore_data_o (restore_data)
  );

endmodule

//--- testbench/rename_props.sv
`timescale 1ns/1ns
/* Rename stage properties
   Assertions bound into rename_top for ready/valid, free-list count and checkpoint pushes */
module rename_props (
  input logic                clk,
  input logic                rst,
  input logic                rsp_vld_i,
  input logic                rename_ready_i,
  input rename_pkg::fl_cnt_t fl_count_i,     // Free-list occupancy
  input logic                ckpt_push_i,
  input logic                ckpt_full_i
);

  // No response while stalled
  vld_needs_ready: assert property (
    @(posedge clk) disable iff (rst) rsp_vld_i |-> rename_ready_i
  ) else $error("rsp_vld_o high while rename_ready_o is low");

  // At most 32 free tags
  count_in_range: assert property (
    @(posedge clk) disable iff (rst)
      fl_count_i <= rename_pkg::fl_cnt_t'(rename_pkg::FL_DEPTH)
  ) else $error("free-list count above its depth");

  push_not_full: assert property (
    @(posedge clk) disable iff (rst) ckpt_push_i |-> !ckpt_full_i
  ) else $error("checkpoint pushed into a full queue");

endmodule

bind rename_top rename_props rename_props_i (
  .clk            (clk),
  .rst            (rst),
  .rsp_vld_i      (rsp_vld_o),
  .rename_ready_i (rename_ready_o),
  .fl_count_i     (free_list_i.count_q),
  .ckpt_push_i    (push),
  .ckpt_full_i    (ckpt_full)
);

//--- testbench/rename_tb.sv
`timescale 1ns/1ns
/* Rename stage testbench
   Directed table, then xorshift traffic checked against a reference model */
module rename_tb;

  typedef struct packed {
    logic                    dispatch;
    rename_pkg::rename_req_t req;
    logic                    retire_en;
    rename_pkg::preg_t       retire_preg;
    logic                    resolve_en;
    logic                    mispredict;
  } stim_t;

  typedef struct packed {
    logic              vld;
    logic              ready;
    rename_pkg::preg_t ps1;
    rename_pkg::preg_t ps2;
    rename_pkg::preg_t pd;
    rename_pkg::preg_t old_pd;
  } expect_t;

  typedef struct packed {
    stim_t   stim;
    expect_t exp;
  } row_t;

  logic                    clk;
  logic                    rst;
  logic                    dispatch_en;
  rename_pkg::rename_req_t req;
  logic                    retire_en;
  rename_pkg::preg_t       retire_preg;
  logic                    resolve_en;
  logic                    mispredict;
  rename_pkg::rename_rsp_t rsp;
  logic                    rsp_vld;
  logic                    rename_ready;

  row_t        rows [$];           // Directed table
  int          rand_steps   = 600;
  int          reset_cycles = 5;
  int          mismatch_cnt = 0;
  int          other_cnt    = 0;
  logic [31:0] rng_state    = 32'd33;

  // Reference model
  rename_pkg::map_t    map_m;
  rename_pkg::preg_t   fl_m [rename_pkg::FL_DEPTH];
  rename_pkg::fl_ptr_t head_m;
  rename_pkg::fl_ptr_t tail_m;
  int                  count_m;
  rename_pkg::map_t    ck_map_q [$];
  rename_pkg::fl_ptr_t ck_head_q [$];
  int                  ck_seq_q [$];   // Pending-retire sequence at each branch
  rename_pkg::preg_t   pend_q [$];     // Old tags waiting for retire, oldest first
  int                  pushed_seq;
  int                  popped_seq;
  int                  bypass_seen      = 0;
  int                  empty_stall_seen = 0;
  int                  full_stall_seen  = 0;
  int                  restore_seen     = 0;

  rename_top rename_top_i (
    .clk            (clk),
    .rst            (rst),
    .dispatch_en_i  (dispatch_en),
    .req_i          (req),
    .retire_en_i    (retire_en),
    .retire_preg_i  (retire_preg),
    .resolve_en_i   (resolve_en),
    .mispredict_i   (mispredict),
    .rsp_o          (rsp),
    .rsp_vld_o      (rsp_vld),
    .rename_ready_o (rename_ready)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #4 clk = ~clk;  // 8 ns period
    end
  end

  function automatic logic [31:0] next_rand(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic row_t make_row(input int d, hd, br, rd, rs1, rs2, ret, rp, res, mis,
                                    input int vld, rdy, ps1, ps2, pd, opd);
    row_t r;
    r.stim.dispatch      = d[0];
    r.stim.req.has_dest  = hd[0];
    r.stim.req.is_branch = br[0];
    r.stim.req.rd        = rename_pkg::areg_t'(rd);
    r.stim.req.rs1       = rename_pkg::areg_t'(rs1);
    r.stim.req.rs2       = rename_pkg::areg_t'(rs2);
    r.stim.retire_en     = ret[0];
    r.stim.retire_preg   = rename_pkg::preg_t'(rp);
    r.stim.resolve_en    = res[0];
    r.stim.mispredict    = mis[0];
    r.exp.vld            = vld[0];
    r.exp.ready          = rdy[0];
    r.exp.ps1            = rename_pkg::preg_t'(ps1);
    r.exp.ps2            = rename_pkg::preg_t'(ps2);
    r.exp.pd             = rename_pkg::preg_t'(pd);
    r.exp.old_pd         = rename_pkg::preg_t'(opd);
    return r;
  endfunction

  task automatic build_table();
    //                  d hd br rd rs1 rs2 ret rp res mis vld rdy ps1 ps2 pd opd
    rows.push_back(make_row(1, 1, 0, 1, 2, 3, 0, 0, 0, 0, 1, 1, 2, 3, 32, 1));
    rows.push_back(make_row(1, 1, 0, 2, 1, 1, 0, 0, 0, 0, 1, 1, 32, 32, 33, 2));
    rows.push_back(make_row(1, 1, 0, 1, 2, 5, 0, 0, 0, 0, 1, 1, 33, 5, 34, 32));
    rows.push_back(make_row(1, 0, 1, 0, 1, 2, 0, 0, 0, 0, 1, 1, 34, 33, 0, 0));  // Branch, head 3
    rows.push_back(make_row(1, 1, 0, 1, 1, 0, 0, 0, 0, 0, 1, 1, 34, 0, 35, 34));
    rows.push_back(make_row(1, 1, 0, 3, 1, 3, 0, 0, 0, 0, 1, 1, 35, 3, 36, 3));
    rows.push_back(make_row(1, 1, 0, 4, 1, 3, 0, 0, 1, 1, 0, 1, 0, 0, 0, 0));    // Mispredict
    rows.push_back(make_row(1, 1, 0, 4, 1, 3, 1, 1, 0, 0, 1, 1, 34, 3, 35, 4));  // Map rolled back
    rows.push_back(make_row(1, 0, 1, 0, 4, 2, 0, 0, 0, 0, 1, 1, 35, 33, 0, 0));
    rows.push_back(make_row(1, 0, 1, 0, 0, 0, 0, 0, 0, 0, 1, 1, 0, 0, 0, 0));
    rows.push_back(make_row(1, 0, 1, 0, 0, 0, 0, 0, 0, 0, 1, 1, 0, 0, 0, 0));
    rows.push_back(make_row(1, 0, 1, 0, 0, 0, 0, 0, 0, 0, 1, 1, 0, 0, 0, 0));    // 4 in flight
    rows.push_back(make_row(1, 0, 1, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0));    // Fifth stalls
    rows.push_back(make_row(1, 0, 1, 0, 0, 0, 0, 0, 1, 0, 0, 0, 0, 0, 0, 0));    // Still full
    rows.push_back(make_row(1, 0, 1, 0, 1, 2, 0, 0, 0, 0, 1, 1, 34, 33, 0, 0));  // Slot freed
    rows.push_back(make_row(0, 0, 0, 0, 0, 0, 0, 0, 1, 0, 0, 1, 0, 0, 0, 0));
  endtask

  task automatic drive(input stim_t s);
    dispatch_en = s.dispatch;
    req         = s.req;
    retire_en   = s.retire_en;
    retire_preg = s.retire_preg;
    resolve_en  = s.resolve_en;
    mispredict  = s.mispredict;
  endtask

  // Caller sits at time 0 or on a falling edge
  task automatic apply_reset();
    rst = 1'b1;
    drive('0);
    repeat (reset_cycles) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
  endtask

  task automatic compare_field(input string what, input int got, input int exp);
    assert (got == exp) else begin
      mismatch_cnt++;
      $display("MISMATCH at %0t ns: %s got %0d expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_outputs(input expect_t e, input string ctx);
    compare_field({ctx, " ready"}, int'(rename_ready), int'(e.ready));
    compare_field({ctx, " vld"}, int'(rsp_vld), int'(e.vld));
    if (e.vld) begin  // Tags only mean something on a rename
      compare_field({ctx, " ps1"}, int'(rsp.ps1), int'(e.ps1));
      compare_field({ctx, " ps2"}, int'(rsp.ps2), int'(e.ps2));
      compare_field({ctx, " pd"}, int'(rsp.pd), int'(e.pd));
      compare_field({ctx, " old_pd"}, int'(rsp.old_pd), int'(e.old_pd));
    end
  endtask

  task automatic model_reset();
    for (int r = 0; r < rename_pkg::NUM_AREG; r++) begin
      map_m[r] = rename_pkg::preg_t'(r);
    end
    for (int i = 0; i < rename_pkg::FL_DEPTH; i++) begin
      fl_m[i] = rename_pkg::preg_t'(rename_pkg::NUM_AREG + i);  // p32..p63
    end
    head_m  = '0;
    tail_m  = '0;
    count_m = rename_pkg::FL_DEPTH;
    ck_map_q.delete();
    ck_head_q.delete();
    ck_seq_q.delete();
    pend_q.delete();
    pushed_seq = 0;
    popped_seq = 0;
  endtask

  // Expected outputs from the current state, then advance one clock
  task automatic model_step(input stim_t s, output expect_t e, output rename_pkg::fl_ptr_t e_head);
    logic restore;
    logic empty;
    logic alloc;
    logic bypass;
    logic ck_full;
    restore  = s.resolve_en & s.mispredict;
    empty    = (count_m == 0);
    ck_full  = (ck_map_q.size() == rename_pkg::CKPT_DEPTH);
    e.ready  = !(s.req.has_dest && empty && !s.retire_en) && !(s.req.is_branch && ck_full);
    e.vld    = s.dispatch & e.ready & ~restore;
    e.ps1    = map_m[s.req.rs1];
    e.ps2    = map_m[s.req.rs2];
    e.old_pd = map_m[s.req.rd];
    e.pd     = !s.req.has_dest ? '0 : (empty ? s.retire_preg : fl_m[head_m]);
    e_head   = head_m;
    alloc    = e.vld & s.req.has_dest;
    bypass   = alloc & empty & s.retire_en;  // Retired tag handed straight over
    if (bypass) bypass_seen++;
    if (s.dispatch && s.req.has_dest && empty && !s.retire_en) empty_stall_seen++;
    if (s.dispatch && s.req.is_branch && ck_full) full_stall_seen++;
    if (s.retire_en) begin
      void'(pend_q.pop_front());
      popped_seq++;
    end
    if (restore) begin
      restore_seen++;
      count_m = count_m + int'(rename_pkg::fl_ptr_t'(head_m - ck_head_q[0]));
      head_m  = ck_head_q[0];
      map_m   = ck_map_q[0];
      while (popped_seq + pend_q.size() > ck_seq_q[0]) begin
        void'(pend_q.pop_back());  // Squashed work never retires
      end
      pushed_seq = ck_seq_q[0];
      ck_map_q.delete();
      ck_head_q.delete();
      ck_seq_q.delete();
    end else begin
      if (alloc && !bypass) begin
        head_m  = rename_pkg::fl_ptr_t'(head_m + 1);
        count_m = count_m - 1;
      end
      if (e.vld && s.req.is_branch) begin  // Map before own write, head after alloc
        ck_map_q.push_back(map_m);
        ck_head_q.push_back(head_m);
        ck_seq_q.push_back(pushed_seq);
      end
      if (alloc) begin
        map_m[s.req.rd] = e.pd;
        pend_q.push_back(e.old_pd);
        pushed_seq++;
      end
      if (s.resolve_en && ck_map_q.size() > 0) begin  // Correct branch
        void'(ck_map_q.pop_front());
        void'(ck_head_q.pop_front());
        void'(ck_seq_q.pop_front());
      end
    end
    if (s.retire_en && !bypass) begin
      fl_m[tail_m] = s.retire_preg;
      tail_m       = rename_pkg::fl_ptr_t'(tail_m + 1);
      count_m      = count_m + 1;
    end
  endtask

  // Legal random traffic, only tags older than every open branch retire
  task automatic gen_stim(output stim_t s);
    logic [31:0] r;
    int          retirable;
    rng_state = next_rand(rng_state);
    r         = rng_state;
    s         = '0;
    s.dispatch      = r[0] | r[1];
    s.req.is_branch = (r[4:2] == 3'd0);
    s.req.has_dest  = ~s.req.is_branch & (r[5] | r[6]);
    s.req.rd        = r[11:7];
    s.req.rs1       = r[16:12];
    s.req.rs2       = r[21:17];
    retirable = (ck_seq_q.size() > 0) ? ck_seq_q[0] - popped_seq : pend_q.size();
    if (r[23:22] == 2'd0 && retirable > 0) begin
      s.retire_en   = 1'b1;
      s.retire_preg = pend_q[0];
    end
    if (r[27:24] == 4'd0 && ck_seq_q.size() > 0) begin
      s.resolve_en = 1'b1;
      s.mispredict = r[28] & r[29];  // About a quarter of resolves
    end
  endtask

  task automatic require_event(input string what, input int n);
    assert (n > 0) else begin
      other_cnt++;
      $display("Random phase never produced %s", what);
    end
  endtask

  task automatic run_watchdog(input int limit_ns);
    #(limit_ns);
    $display("Timeout after %0d ns, the run did not finish", limit_ns);
    $display("Test FAILED");
    $finish;
  endtask

  initial begin
    stim_t               s;
    expect_t             e;
    rename_pkg::fl_ptr_t e_head;
    rst = 1'b1;
    drive('0);
    build_table();
    fork
      run_watchdog((rows.size() + rand_steps + 2 * reset_cycles) * 8 * 2);
    join_none
    apply_reset();
    foreach (rows[i]) begin
      drive(rows[i].stim);
      #2;  // Outputs settled in the low phase
      check_outputs(rows[i].exp, $sformatf("row %0d", i));
      @(negedge clk);
    end
    apply_reset();
    model_reset();
    for (int n = 0; n < rand_steps; n++) begin
      gen_stim(s);
      model_step(s, e, e_head);
      drive(s);
      #2;
      check_outputs(e, $sformatf("step %0d", n));
      if (e.vld) compare_field($sformatf("step %0d fl_head", n), int'(rsp.fl_head), int'(e_head));
      @(negedge clk);
    end
    require_event("an empty-list bypass", bypass_seen);
    require_event("an empty-list stall", empty_stall_seen);
    require_event("a full checkpoint stall", full_stall_seen);
    require_event("a mispredict restore", restore_seen);
    $display("Errors: %0d mismatches, %0d other", mismatch_cnt, other_cnt);
    if (mismatch_cnt == 0 && other_cnt == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

//--- rename.f
logic/rename_pkg.sv
logic/free_list.sv
logic/map_table.sv
logic/checkpoint_queue.sv
logic/rename_top.sv
testbench/rename_props.sv
testbench/rename_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the rename stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module rename_tb -f rename.f -o rename_sim
./obj_dir/rename_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx "Test OK" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi
